/* hdl/idt_entry_capture.sv */
`include "ie_defines.svh"

module idt_entry_capture
    import ie_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ld_info_regs,
    input  ie_type_t    ie_type,
    input  ie_addr_t    idtr_base,
    input  ie_addr_t    eip_wb,
    input  ie_eflags_t  eflags_wb,
    input  ie_cs_t      cs_wb,
    output ie_context_t ctx
);

    ie_addr_t vector;
    ie_addr_t entry;
    ie_addr_t entry_sel;

    // lowest set type bit wins
    always_comb begin
        if (ie_type[0]) begin
            vector = ie_addr_t'(`IE_VEC_PROT);
        end else if (ie_type[1]) begin
            vector = ie_addr_t'(`IE_VEC_PAGE);
        end else if (ie_type[2]) begin
            vector = ie_addr_t'(`IE_VEC_INTR);
        end else begin
            vector = '0;
        end
    end

    // base + 8 * vector, selector word sits above the offset
    assign entry     = idtr_base + (vector << `IE_ENTRY_STRIDE_SHIFT);
    assign entry_sel = entry + ie_addr_t'(`IE_SELECTOR_OFFSET);

    // tracks writeback while idle, frozen for the whole service
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctx <= '0;
        end else if (ld_info_regs) begin
            ctx.entry     <= entry;
            ctx.entry_sel <= entry_sel;
            ctx.eip       <= eip_wb;
            ctx.eflags    <= eflags_wb;
            ctx.cs        <= cs_wb;
        end
    end

endmodule

/* hdl/ie_control.sv */
module ie_control
    import ie_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      enable,
    input  logic      ie_in,
    input  logic      is_iretd,
    input  logic      rrag_stall,
    input  logic      is_final_switch_wb,
    output ie_state_t state,
    output logic      packet_valid,
    output logic      flush_pipe,
    output logic      ld_eip,
    output logic      ld_info_regs,
    output logic      is_pop_eflags,
    output logic      servicing_ie,
    output logic      switching,
    output logic      invalidate_fetch
);

    ie_state_t state_nxt;
    logic      is_pkt;
    logic      is_final;
    logic      issued;
    logic      ret_flush;

    // states that put a packet on the fetch bus
    always_comb begin
        case (state)
            S_PUSH_EFLAGS, S_PUSH_CS, S_PUSH_EIP,
            S_LOAD_OFFSET, S_LOAD_SELECTOR,
            S_EXCHANGE, S_SHIFT_SEL, S_MOV_CS, S_JUMP,
            S_MOV_EFLAGS, S_RET_FAR, S_ADD_ESP: is_pkt = 1'b1;
            default:                            is_pkt = 1'b0;
        endcase
    end

    // jump into the isr and far return out of it
    assign is_final = (state == S_JUMP) || (state == S_RET_FAR);

    always_comb begin
        state_nxt = state;
        if (is_final) begin
            // wait for the switch instruction to retire
            if (issued && is_final_switch_wb) begin
                state_nxt = (state == S_JUMP) ? S_IN_ISR : S_ADD_ESP;
            end
        end else if (!(is_pkt && rrag_stall)) begin
            case (state)
                S_IDLE: begin
                    if (enable && ie_in) begin
                        state_nxt = S_FLUSH;
                    end
                end
                S_FLUSH:         state_nxt = S_PUSH_EFLAGS;
                S_PUSH_EFLAGS:   state_nxt = S_PUSH_CS;
                S_PUSH_CS:       state_nxt = S_PUSH_EIP;
                S_PUSH_EIP:      state_nxt = S_LOAD_OFFSET;
                S_LOAD_OFFSET:   state_nxt = S_LOAD_SELECTOR;
                S_LOAD_SELECTOR: state_nxt = S_EXCHANGE;
                S_EXCHANGE:      state_nxt = S_SHIFT_SEL;
                S_SHIFT_SEL:     state_nxt = S_MOV_CS;
                S_MOV_CS:        state_nxt = S_JUMP;
                S_IN_ISR: begin
                    // stay in the routine until iretd
                    if (is_iretd) begin
                        state_nxt = S_MOV_EFLAGS;
                    end
                end
                S_MOV_EFLAGS:    state_nxt = S_RET_FAR;
                S_ADD_ESP:       state_nxt = S_IDLE;
                default:         state_nxt = S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            issued    <= 1'b0;
            ret_flush <= 1'b0;
        end else begin
            state     <= state_nxt;
            // set once the switch packet leaves unstalled, cleared on exit
            issued    <= is_final && (state_nxt == state) && (issued || !rrag_stall);
            // one more flush on the way back to idle
            ret_flush <= (state == S_ADD_ESP) && (state_nxt == S_IDLE);
        end
    end

    // single valid pulse in the switch states, then fetch is invalidated
    assign packet_valid     = is_pkt && !(is_final && issued);
    assign invalidate_fetch = is_final && issued;

    assign flush_pipe    = (state == S_FLUSH) || ret_flush;
    assign ld_info_regs  = (state == S_IDLE);
    // eip follows writeback outside the sequences
    assign ld_eip        = (state == S_IDLE) || (state == S_IN_ISR);
    assign is_pop_eflags = (state == S_MOV_EFLAGS);
    assign servicing_ie  = (state != S_IDLE) && (state != S_FLUSH);
    assign switching     = (state != S_IDLE) && (state != S_IN_ISR);

endmodule

/* hdl/ie_defines.svh */
`ifndef IE_DEFINES_SVH
`define IE_DEFINES_SVH

// datapath widths
`define IE_ADDR_W               32
`define IE_PACKET_W             128
`define IE_EFLAGS_W             18
`define IE_CS_W                 16

// vector numbers per type bit
`define IE_VEC_PROT             13
`define IE_VEC_PAGE             14
`define IE_VEC_INTR             15

// idt entries are 8 bytes, selector word 4 bytes in
`define IE_ENTRY_STRIDE_SHIFT   3
`define IE_SELECTOR_OFFSET      4

// opcode prefixes, sized so packets can be left-justified
`define IE_OP_PUSH              8'h68
`define IE_OP_MOV_EBP           24'h668b2e
`define IE_OP_MOV_EDI           24'h668b3e
`define IE_OP_XCHG              16'h87fd
`define IE_OP_SAR               32'h66c1fd04
`define IE_OP_MOV_CS            16'h8ecd
`define IE_OP_JMP               24'h66ffe7
`define IE_OP_MOV_STACK         48'h6766896c2408
`define IE_OP_RET_FAR           8'hcb
`define IE_OP_ADD_ESP           32'h6683c404

`endif

/* hdl/ie_handler.sv */
module ie_handler
    import ie_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    input  logic       ie_in,
    input  ie_type_t   ie_type,
    input  ie_addr_t   idtr_base,
    input  ie_addr_t   eip_wb,
    input  ie_eflags_t eflags_wb,
    input  ie_cs_t     cs_wb,
    input  logic       is_iretd,
    input  logic       rrag_stall,
    input  logic       is_final_switch_wb,
    output ie_packet_t packet_out,
    output logic       packet_valid,
    output logic       flush_pipe,
    output logic       ld_eip,
    output logic       ld_info_regs,
    output logic       is_pop_eflags,
    output logic       servicing_ie,
    output logic       switching,
    output logic       invalidate_fetch
);

    ie_state_t   state;
    ie_context_t ctx;

    // sequencer
    ie_control ie_control_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .enable             (enable),
        .ie_in              (ie_in),
        .is_iretd           (is_iretd),
        .rrag_stall         (rrag_stall),
        .is_final_switch_wb (is_final_switch_wb),
        .state              (state),
        .packet_valid       (packet_valid),
        .flush_pipe         (flush_pipe),
        .ld_eip             (ld_eip),
        .ld_info_regs       (ld_info_regs),
        .is_pop_eflags      (is_pop_eflags),
        .servicing_ie       (servicing_ie),
        .switching          (switching),
        .invalidate_fetch   (invalidate_fetch)
    );

    // return context and idt addresses
    idt_entry_capture idt_entry_capture_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .ld_info_regs (ld_info_regs),
        .ie_type      (ie_type),
        .idtr_base    (idtr_base),
        .eip_wb       (eip_wb),
        .eflags_wb    (eflags_wb),
        .cs_wb        (cs_wb),
        .ctx          (ctx)
    );

    // packet per state, same cycle
    isr_packet_gen isr_packet_gen_inst (
        .state      (state),
        .ctx        (ctx),
        .packet_out (packet_out)
    );

endmodule

/* hdl/ie_pkg.sv */
`include "ie_defines.svh"

package ie_pkg;

    // address or 32-bit immediate
    typedef logic [`IE_ADDR_W-1:0]   ie_addr_t;
    // one fetch packet, left-justified
    typedef logic [`IE_PACKET_W-1:0] ie_packet_t;
    // bit 0 protection, bit 1 page fault, bit 2 interrupt
    typedef logic [2:0]              ie_type_t;
    typedef logic [`IE_EFLAGS_W-1:0] ie_eflags_t;
    typedef logic [`IE_CS_W-1:0]     ie_cs_t;

    // entry run, service wait, return run
    typedef enum logic [3:0] {
        S_IDLE,
        S_FLUSH,
        S_PUSH_EFLAGS,
        S_PUSH_CS,
        S_PUSH_EIP,
        S_LOAD_OFFSET,
        S_LOAD_SELECTOR,
        S_EXCHANGE,
        S_SHIFT_SEL,
        S_MOV_CS,
        S_JUMP,
        S_IN_ISR,
        S_MOV_EFLAGS,
        S_RET_FAR,
        S_ADD_ESP
    } ie_state_t;

    // latched return context plus both idt addresses
    typedef struct packed {
        ie_addr_t   entry;
        ie_addr_t   entry_sel;
        ie_addr_t   eip;
        ie_eflags_t eflags;
        ie_cs_t     cs;
    } ie_context_t;

endpackage

/* hdl/isr_packet_gen.sv */
`include "ie_defines.svh"

module isr_packet_gen
    import ie_pkg::*;
(
    input  ie_state_t   state,
    input  ie_context_t ctx,
    output ie_packet_t  packet_out
);

    ie_packet_t push_eflags, push_cs, push_eip;
    ie_packet_t mov_ebp, mov_edi;
    ie_packet_t xchg, sar_sel, mov_cs, jmp_edi;
    ie_packet_t mov_stack, ret_far, add_esp;

    // immediates go out little-endian
    function automatic ie_addr_t swap32(input ie_addr_t v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    // pushes of the zero-extended return context
    assign push_eflags = {`IE_OP_PUSH, swap32(ie_addr_t'(ctx.eflags)),
                          {(`IE_PACKET_W - 8 - `IE_ADDR_W){1'b0}}};
    assign push_cs     = {`IE_OP_PUSH, swap32(ie_addr_t'(ctx.cs)),
                          {(`IE_PACKET_W - 8 - `IE_ADDR_W){1'b0}}};
    assign push_eip    = {`IE_OP_PUSH, swap32(ctx.eip),
                          {(`IE_PACKET_W - 8 - `IE_ADDR_W){1'b0}}};

    // idt loads, offset into ebp and selector into edi
    assign mov_ebp = {`IE_OP_MOV_EBP, swap32(ctx.entry),
                      {(`IE_PACKET_W - 24 - `IE_ADDR_W){1'b0}}};
    assign mov_edi = {`IE_OP_MOV_EDI, swap32(ctx.entry_sel),
                      {(`IE_PACKET_W - 24 - `IE_ADDR_W){1'b0}}};

    // fixed packets without immediate
    assign xchg      = {`IE_OP_XCHG,      {(`IE_PACKET_W - 16){1'b0}}};
    assign sar_sel   = {`IE_OP_SAR,       {(`IE_PACKET_W - 32){1'b0}}};
    assign mov_cs    = {`IE_OP_MOV_CS,    {(`IE_PACKET_W - 16){1'b0}}};
    assign jmp_edi   = {`IE_OP_JMP,       {(`IE_PACKET_W - 24){1'b0}}};
    assign mov_stack = {`IE_OP_MOV_STACK, {(`IE_PACKET_W - 48){1'b0}}};
    assign ret_far   = {`IE_OP_RET_FAR,   {(`IE_PACKET_W - 8){1'b0}}};
    assign add_esp   = {`IE_OP_ADD_ESP,   {(`IE_PACKET_W - 32){1'b0}}};

    // idle, flush and isr wait give zero
    always_comb begin
        case (state)
            S_PUSH_EFLAGS:   packet_out = push_eflags;
            S_PUSH_CS:       packet_out = push_cs;
            S_PUSH_EIP:      packet_out = push_eip;
            S_LOAD_OFFSET:   packet_out = mov_ebp;
            S_LOAD_SELECTOR: packet_out = mov_edi;
            S_EXCHANGE:      packet_out = xchg;
            S_SHIFT_SEL:     packet_out = sar_sel;
            S_MOV_CS:        packet_out = mov_cs;
            S_JUMP:          packet_out = jmp_edi;
            S_MOV_EFLAGS:    packet_out = mov_stack;
            S_RET_FAR:       packet_out = ret_far;
            S_ADD_ESP:       packet_out = add_esp;
            default:         packet_out = '0;
        endcase
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# verilator build and run, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_ie_handler -f sim.f -o tb_ie_handler \
    && ./obj_dir/tb_ie_handler > sim.log 2>&1 \
    && cat sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -qx "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim.f */
+incdir+hdl
hdl/ie_pkg.sv
hdl/ie_control.sv
hdl/idt_entry_capture.sv
hdl/isr_packet_gen.sv
hdl/ie_handler.sv
verification/ie_checker.sv
verification/tb_ie_handler.sv

/* verification/ie_checker.sv */
module ie_checker
    import ie_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       new_row,
    // 1 idle levels, 2 service levels and entry counts, 3 idle levels and full counts
    input  logic [1:0] check,
    input  ie_packet_t exp_pkt [12],
    input  ie_packet_t packet_out,
    input  logic       rrag_stall,
    // valid, flush, ld_eip, ld_info, pop_eflags, servicing, switching, invalidate
    input  logic [7:0] ctrl,
    output int         errors
);

    int err_count   = 0;
    int pkt_count   = 0;
    int flush_count = 0;

    assign errors = err_count;

    task automatic compare(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("FAILED %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    // mid-cycle sampling, inputs and outputs settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (ctrl[7]) begin
                if (pkt_count > 11) begin
                    err_count++;
                    $display("packet %0h came after the end of the sequence", packet_out);
                end else begin
                    compare("packet_out", packet_out, exp_pkt[pkt_count]);
                end
                // stalled packet is held and seen again
                if (!rrag_stall) begin
                    pkt_count <= pkt_count + 1;
                end
            end
            if (ctrl[6]) begin
                flush_count <= flush_count + 1;
                // both flushes sit outside the service
                compare("servicing_ie", 128'(ctrl[2]), 128'd0);
            end
            // packets and switch waits lie inside the sequence
            if (ctrl[7] || ctrl[0]) begin
                compare("servicing_ie", 128'(ctrl[2]), 128'd1);
                compare("switching", 128'(ctrl[1]), 128'd1);
            end
            // pop only alongside the mov-to-stack packet
            compare("is_pop_eflags", 128'(ctrl[3]), 128'(ctrl[7] && pkt_count == 9));
            if (ctrl[7] && ctrl[0]) begin
                err_count++;
                $display("packet_valid and invalidate_fetch are high together");
            end
            if (check != 2'd0) begin
                compare("ctrl", 128'(ctrl), (check == 2'd2) ? 128'h24 : 128'h30);
            end
            if (check == 2'd2) begin
                compare("pkt_count", 128'(pkt_count), 128'd9);
                compare("flush_count", 128'(flush_count), 128'd1);
            end
            if (check == 2'd3) begin
                compare("pkt_count", 128'(pkt_count), 128'd12);
                compare("flush_count", 128'(flush_count), 128'd2);
            end
            // fresh sequence, counts start over
            if (new_row) begin
                pkt_count   <= 0;
                flush_count <= 0;
            end
        end
    end

endmodule

/* verification/tb_ie_handler.sv */
module tb_ie_handler
    import ie_pkg::*;
();

    // one stimulus row with its expected vector
    typedef struct packed {
        ie_type_t   ie_type;
        ie_addr_t   idtr_base;
        ie_addr_t   eip;
        ie_eflags_t eflags;
        ie_cs_t     cs;
        logic       stall_en;
        logic [7:0] exp_vec;
    } row_t;

    localparam int N_ROWS  = 5;
    localparam int TIMEOUT = 100;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic        ie_in;
    logic        is_iretd;
    logic        rrag_stall;
    logic        is_final_switch_wb;
    ie_type_t    ie_type;
    ie_addr_t    idtr_base;
    ie_addr_t    eip_wb;
    ie_eflags_t  eflags_wb;
    ie_cs_t      cs_wb;
    ie_packet_t  packet_out;
    logic [7:0]  ctrl;
    ie_packet_t  exp_pkt [12];
    row_t        rows [N_ROWS];
    logic        new_row;
    logic [1:0]  check;
    logic        stall_on;
    logic [31:0] rng;
    int          chk_errors;
    int          timeouts;

    ie_handler ie_handler_inst (
        .*,
        .packet_valid     (ctrl[7]),
        .flush_pipe       (ctrl[6]),
        .ld_eip           (ctrl[5]),
        .ld_info_regs     (ctrl[4]),
        .is_pop_eflags    (ctrl[3]),
        .servicing_ie     (ctrl[2]),
        .switching        (ctrl[1]),
        .invalidate_fetch (ctrl[0])
    );

    ie_checker ie_checker_inst (
        .*,
        .errors (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // opcode bytes first, then the immediate with its low byte first
    function automatic ie_packet_t build_packet(input logic [47:0] op, input int n_op,
                                                input logic [31:0] imm, input int n_imm);
        ie_packet_t p;
        p = '0;
        for (int i = 0; i < n_op; i++) begin
            p[127-8*i -: 8] = op[8*(n_op-1-i) +: 8];
        end
        for (int j = 0; j < n_imm; j++) begin
            p[127-8*(n_op+j) -: 8] = imm[8*j +: 8];
        end
        return p;
    endfunction

    // the twelve packets of one entry and return
    task automatic fill_expected(input row_t r);
        ie_addr_t entry;
        entry = r.idtr_base + 32'(r.exp_vec) * 8;
        exp_pkt[0]  = build_packet(48'h68, 1, 32'(r.eflags), 4);
        exp_pkt[1]  = build_packet(48'h68, 1, 32'(r.cs), 4);
        exp_pkt[2]  = build_packet(48'h68, 1, r.eip, 4);
        exp_pkt[3]  = build_packet(48'h668b2e, 3, entry, 4);
        exp_pkt[4]  = build_packet(48'h668b3e, 3, entry + 32'd4, 4);
        exp_pkt[5]  = build_packet(48'h87fd, 2, 32'd0, 0);
        exp_pkt[6]  = build_packet(48'h66c1fd04, 4, 32'd0, 0);
        exp_pkt[7]  = build_packet(48'h8ecd, 2, 32'd0, 0);
        exp_pkt[8]  = build_packet(48'h66ffe7, 3, 32'd0, 0);
        exp_pkt[9]  = build_packet(48'h6766896c2408, 6, 32'd0, 0);
        exp_pkt[10] = build_packet(48'hcb, 1, 32'd0, 0);
        exp_pkt[11] = build_packet(48'h6683c404, 4, 32'd0, 0);
    endtask

    // next cycle, inputs change a little after the edge
    task automatic step();
        @(posedge clk);
        #2;
        rng = xorshift32(rng);
        rrag_stall = stall_on && rng[0];
    endtask

    // 0 switch packet issued, 1 in the routine, 2 idle after the return flush
    function automatic logic reached(input int goal);
        case (goal)
            0:       return ctrl[0];
            1:       return ctrl[2] && !ctrl[1];
            default: return ctrl[4] && !ctrl[6];
        endcase
    endfunction

    task automatic wait_until(input int goal, input string what);
        int n;
        n = 0;
        while (timeouts == 0 && !reached(goal)) begin
            step();
            n++;
            if (n > TIMEOUT) begin
                timeouts++;
                $display("timeout while waiting for %s", what);
            end
        end
    endtask

    // one-cycle strobe to the checker
    task automatic request_check(input logic [1:0] kind);
        check = kind;
        step();
        check = 2'd0;
    endtask

    // switch instruction retires after a random writeback delay
    task automatic retire_switch();
        repeat (1 + int'(rng[2:0])) step();
        is_final_switch_wb = 1'b1;
        step();
        is_final_switch_wb = 1'b0;
    endtask

    initial begin
        rng                = 32'h2e93_9b0d;
        rst_n              = 1'b0;
        enable             = 1'b0;
        ie_in              = 1'b0;
        is_iretd           = 1'b0;
        rrag_stall         = 1'b0;
        is_final_switch_wb = 1'b0;
        ie_type            = '0;
        idtr_base          = '0;
        eip_wb             = '0;
        eflags_wb          = '0;
        cs_wb              = '0;
        new_row            = 1'b0;
        check              = 2'd0;
        stall_on           = 1'b0;
        timeouts           = 0;
        for (int k = 0; k < 12; k++) begin
            exp_pkt[k] = '0;
        end
        // type, idtr base, eip, eflags, cs, stall, expected vector
        rows[0] = {3'b001, 32'h0008_0000, 32'h0040_1a2c, 18'h3_0246, 16'h0008, 1'b0, 8'd13};
        rows[1] = {3'b010, 32'h0010_0400, 32'hc012_3456, 18'h0_0202, 16'h001b, 1'b1, 8'd14};
        rows[2] = {3'b100, 32'h7ff0_0000, 32'h8000_fff0, 18'h2_1003, 16'hf00d, 1'b1, 8'd15};
        rows[3] = {3'b110, 32'h0000_1000, 32'h1234_5678, 18'h1_0a97, 16'h0023, 1'b1, 8'd14};
        rows[4] = {3'b111, 32'hffff_ff80, 32'hdead_beef, 18'h3_ffff, 16'hffff, 1'b1, 8'd13};
        repeat (16) step();
        rst_n  = 1'b1;
        enable = 1'b1;
        request_check(2'd1);
        for (int r = 0; r < N_ROWS; r++) begin
            fill_expected(rows[r]);
            stall_on  = rows[r].stall_en;
            ie_type   = rows[r].ie_type;
            idtr_base = rows[r].idtr_base;
            eip_wb    = rows[r].eip;
            eflags_wb = rows[r].eflags;
            cs_wb     = rows[r].cs;
            ie_in     = 1'b1;
            new_row   = 1'b1;
            step();
            ie_in   = 1'b0;
            new_row = 1'b0;
            // writeback moves on, latched context must not follow
            ie_type   = ~ie_type;
            idtr_base = ~idtr_base;
            eip_wb    = ~eip_wb;
            eflags_wb = ~eflags_wb;
            cs_wb     = ~cs_wb;
            wait_until(0, "invalidate_fetch after the JMP packet");
            retire_switch();
            wait_until(1, "entry into the service routine");
            request_check(2'd2);
            repeat (1 + int'(rng[2:0])) step();
            is_iretd = 1'b1;
            step();
            is_iretd = 1'b0;
            wait_until(0, "invalidate_fetch after the RET FAR packet");
            retire_switch();
            wait_until(2, "return to idle");
            request_check(2'd3);
        end
        $display("checker errors: %0d, timeouts: %0d", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
